// File: include/rv32_params.svh
/* RV32I encodings for the combinational executor. Only the kept subset is listed:
   no compressed forms, no M extension and no CSR writes. */
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// Major opcodes, low two bits included
`define OPC_LUI      7'b01_101_11
`define OPC_AUIPC    7'b00_101_11
`define OPC_JAL      7'b11_011_11
`define OPC_JALR     7'b11_001_11
`define OPC_BRANCH   7'b11_000_11
`define OPC_LOAD     7'b00_000_11
`define OPC_STORE    7'b01_000_11
`define OPC_OP       7'b01_100_11
`define OPC_OP_IMM   7'b00_100_11
`define OPC_SYSTEM   7'b11_100_11

`define F3_JALR      3'b000
`define F3_BEQ       3'b000
`define F3_BNE       3'b001
`define F3_BLT       3'b100
`define F3_BGE       3'b101
`define F3_BLTU      3'b110
`define F3_BGEU      3'b111

`define F3_LB        3'b000
`define F3_LH        3'b001
`define F3_LW        3'b010
`define F3_LBU       3'b100
`define F3_LHU       3'b101
`define F3_SB        3'b000
`define F3_SH        3'b001
`define F3_SW        3'b010

`define F3_ADD       3'b000
`define F3_SLL       3'b001
`define F3_SLT       3'b010
`define F3_SLTU      3'b011
`define F3_XOR       3'b100
`define F3_SR        3'b101
`define F3_OR        3'b110
`define F3_AND       3'b111
`define F3_CSRRS     3'b010

`define F7_BASE      7'b0000000
`define F7_ALT       7'b0100000  // SUB and SRA/SRAI

// Read-only counters, low then high halves
`define CSR_CYCLE    12'hC00
`define CSR_TIME     12'hC01
`define CSR_INSTRET  12'hC02
`define CSR_CYCLEH   12'hC80
`define CSR_TIMEH    12'hC81
`define CSR_INSTRETH 12'hC82

// Write-back sources
`define WB_NONE      3'd0
`define WB_ALU       3'd1
`define WB_LOAD      3'd2
`define WB_IMM       3'd3
`define WB_LINK      3'd4
`define WB_CSR       3'd5

`define PC_ALIGN_MASK 32'hFFFF_FFFE

`endif

// File: rtl/rv32_pkg.sv
/* Vector types shared by the executor blocks. */
`default_nettype none

package rv32_pkg;

	typedef logic [31:0] word_t;      // Data or address
	typedef logic [4:0]  reg_addr_t;  // x0..x31
	typedef logic [3:0]  strb_t;      // One bit per byte lane
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [63:0] counter_t;
	typedef logic [2:0]  wb_sel_t;    // Holds a WB_* code

endpackage

`default_nettype wire

// File: rtl/rv32_decode.sv
/* Decodes one 32-bit RV32I word. Words with low bits other than 11, reserved funct
   codes and unknown CSRs trap; a trapped word uses no ports and writes nothing. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module rv32_decode (
	input  rv32_pkg::word_t     pc,
	input  rv32_pkg::word_t     insn,
	input  logic                insn_valid,
	input  rv32_pkg::word_t     rs1_rdata,
	input  rv32_pkg::word_t     rs2_rdata,
	input  logic                rs1_ready,
	input  logic                rs2_ready,
	input  logic                rd_ready,
	input  logic                mem_ready,
	output rv32_pkg::reg_addr_t rs1_addr,
	output rv32_pkg::reg_addr_t rs2_addr,
	output rv32_pkg::reg_addr_t rd_addr,
	output logic                rs1_addr_valid,
	output logic                rs2_addr_valid,
	output logic                rd_addr_valid,
	output logic                rs1_request,
	output logic                rs2_request,
	output logic                rd_request,
	output rv32_pkg::word_t     op_a,
	output rv32_pkg::word_t     op_b,
	output rv32_pkg::word_t     imm,
	output rv32_pkg::word_t     insn_addr,
	output rv32_pkg::funct3_t   funct3,
	output logic                alt_op,
	output logic                alu_en,
	output logic                is_load,
	output logic                is_store,
	output logic                is_branch,
	output logic                is_jump,
	output logic                jump_reg,
	output rv32_pkg::wb_sel_t   wb_sel,
	output logic [11:0]         csr_addr,
	output logic                trap,
	output logic                insn_complete
);
	import rv32_pkg::*;

	opcode_t    opcode;
	logic [6:0] funct7;
	reg_addr_t  rs1_field;
	reg_addr_t  rs2_field;
	reg_addr_t  rd_field;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	logic       legal;
	logic       rs1_used;
	logic       rs2_used;
	logic       rd_used;
	logic       mem_used;

	assign opcode    = insn[6:0];
	assign funct3    = insn[14:12];
	assign funct7    = insn[31:25];
	assign rd_field  = insn[11:7];
	assign rs1_field = insn[19:15];
	assign rs2_field = insn[24:20];
	assign csr_addr  = insn[31:20];
	assign insn_addr = {pc[31:1], 1'b0};

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	// Opcode compare covers the low two bits, so 16-bit forms fall to default
	always_comb begin
		case (opcode)
			`OPC_LUI, `OPC_AUIPC, `OPC_JAL: legal = 1'b1;
			`OPC_JALR:   legal = (funct3 == `F3_JALR);
			`OPC_BRANCH: legal = funct3 inside {`F3_BEQ, `F3_BNE, `F3_BLT,
				`F3_BGE, `F3_BLTU, `F3_BGEU};
			`OPC_LOAD:   legal = funct3 inside {`F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU};
			`OPC_STORE:  legal = funct3 inside {`F3_SB, `F3_SH, `F3_SW};
			`OPC_OP:     legal = (funct7 == `F7_BASE) ||
				((funct7 == `F7_ALT) && (funct3 == `F3_ADD || funct3 == `F3_SR));
			`OPC_OP_IMM: begin
				if (funct3 == `F3_SLL)
					legal = (funct7 == `F7_BASE);
				else if (funct3 == `F3_SR)
					legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
				else
					legal = 1'b1;
			end
			// Only CSRRS rd, counter, x0 is accepted
			`OPC_SYSTEM: legal = (funct3 == `F3_CSRRS) && (rs1_field == '0) &&
				(csr_addr inside {`CSR_CYCLE, `CSR_TIME, `CSR_INSTRET,
				`CSR_CYCLEH, `CSR_TIMEH, `CSR_INSTRETH});
			default:     legal = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			`OPC_LUI:    imm = imm_u;
			`OPC_AUIPC:  imm = imm_u + insn_addr;  // Final AUIPC result
			`OPC_JAL:    imm = imm_j;
			`OPC_BRANCH: imm = imm_b;
			`OPC_STORE:  imm = imm_s;
			`OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: imm = imm_i;
			default:     imm = '0;
		endcase
	end

	always_comb begin
		if (!insn_valid || !legal) begin
			wb_sel = `WB_NONE;
		end else begin
			case (opcode)
				`OPC_LUI, `OPC_AUIPC: wb_sel = `WB_IMM;
				`OPC_JAL, `OPC_JALR:  wb_sel = `WB_LINK;
				`OPC_LOAD:            wb_sel = `WB_LOAD;
				`OPC_OP, `OPC_OP_IMM: wb_sel = `WB_ALU;
				`OPC_SYSTEM:          wb_sel = `WB_CSR;
				default:              wb_sel = `WB_NONE;
			endcase
		end
	end

	assign alu_en    = legal && (opcode == `OPC_OP || opcode == `OPC_OP_IMM);
	assign is_load   = legal && (opcode == `OPC_LOAD);
	assign is_store  = legal && (opcode == `OPC_STORE);
	assign is_branch = legal && (opcode == `OPC_BRANCH);
	assign jump_reg  = legal && (opcode == `OPC_JALR);
	assign is_jump   = jump_reg || (legal && opcode == `OPC_JAL);

	// insn[30] is an immediate bit for ADDI, so only shifts honour it in OP-IMM
	assign alt_op = insn[30] && ((opcode == `OPC_OP) ||
		(opcode == `OPC_OP_IMM && funct3 == `F3_SR));

	assign rs1_used = is_jump && jump_reg || is_branch || is_load || is_store || alu_en;
	assign rs2_used = is_branch || is_store || (legal && opcode == `OPC_OP);
	assign rd_used  = legal && !is_branch && !is_store;
	assign mem_used = is_load || is_store;

	assign rs1_addr_valid = insn_valid && rs1_used;
	assign rs2_addr_valid = insn_valid && rs2_used;
	assign rd_addr_valid  = insn_valid && rd_used;

	assign rs1_addr = rs1_addr_valid ? rs1_field : '0;
	assign rs2_addr = rs2_addr_valid ? rs2_field : '0;
	assign rd_addr  = rd_addr_valid  ? rd_field  : '0;

	assign rs1_request = rs1_addr_valid && (rs1_addr != '0);
	assign rs2_request = rs2_addr_valid && (rs2_addr != '0);
	assign rd_request  = rd_addr_valid  && (rd_addr  != '0);

	// x0 reads as zero whatever the register file returns
	assign op_a = (rs1_addr == '0) ? '0 : rs1_rdata;
	assign op_b = (opcode == `OPC_OP_IMM) ? imm_i :
		((rs2_addr == '0) ? '0 : rs2_rdata);

	assign trap = insn_valid && !legal;

	// Ports not used by this word count as ready
	assign insn_complete = insn_valid &&
		(!rs1_addr_valid || rs1_ready) &&
		(!rs2_addr_valid || rs2_ready) &&
		(!rd_addr_valid  || rd_ready)  &&
		(!mem_used       || mem_ready);

endmodule

`default_nettype wire

// File: rtl/rv32_alu.sv
/* OP and OP-IMM datapath. The compare flags are always live for branches; the result
   reads zero outside ALU instructions. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module rv32_alu (
	input  rv32_pkg::word_t   op_a,
	input  rv32_pkg::word_t   op_b,
	input  rv32_pkg::funct3_t funct3,
	input  logic              alt_op,
	input  logic              alu_en,
	output rv32_pkg::word_t   alu_result,
	output logic              lt,
	output logic              ltu,
	output logic              eq
);
	import rv32_pkg::*;

	logic [4:0] shamt;
	word_t      result;

	assign shamt = op_b[4:0];

	assign lt  = $signed(op_a) < $signed(op_b);
	assign ltu = op_a < op_b;
	assign eq  = (op_a == op_b);

	always_comb begin
		case (funct3)
			`F3_ADD:  result = alt_op ? op_a - op_b : op_a + op_b;
			`F3_SLL:  result = op_a << shamt;
			`F3_SLT:  result = {31'b0, lt};
			`F3_SLTU: result = {31'b0, ltu};  // Immediate is sign-extended first
			`F3_XOR:  result = op_a ^ op_b;
			`F3_SR:   result = alt_op ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
			`F3_OR:   result = op_a | op_b;
			`F3_AND:  result = op_a & op_b;
			default:  result = '0;
		endcase
	end

	assign alu_result = alu_en ? result : '0;

endmodule

`default_nettype wire

// File: rtl/rv32_lsu.sv
/* Memory request for loads and stores. Masks are low-aligned and data is not shifted,
   so the memory side handles lane placement for unaligned addresses. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module rv32_lsu (
	input  logic              insn_valid,
	input  logic              is_load,
	input  logic              is_store,
	input  rv32_pkg::funct3_t funct3,
	input  rv32_pkg::word_t   op_a,
	input  rv32_pkg::word_t   imm,
	input  rv32_pkg::word_t   store_data,
	input  rv32_pkg::word_t   mem_rdata,
	output logic              mem_valid,
	output logic              mem_instr,
	output rv32_pkg::word_t   mem_addr,
	output rv32_pkg::word_t   mem_wdata,
	output rv32_pkg::strb_t   mem_wstrb,
	output rv32_pkg::strb_t   mem_rmask,
	output rv32_pkg::word_t   load_data
);
	import rv32_pkg::*;

	logic  do_load;
	logic  do_store;
	strb_t size_mask;

	assign do_load  = insn_valid && is_load;
	assign do_store = insn_valid && is_store;

	assign mem_valid = do_load || do_store;
	assign mem_instr = 1'b0;  // Data accesses only
	assign mem_addr  = mem_valid ? op_a + imm : '0;
	assign mem_wdata = do_store ? store_data : '0;

	// Store sizes reuse the load funct3 values
	always_comb begin
		case (funct3)
			`F3_LB, `F3_LBU: size_mask = 4'b0001;
			`F3_LH, `F3_LHU: size_mask = 4'b0011;
			default:         size_mask = 4'b1111;
		endcase
	end

	assign mem_rmask = do_load  ? size_mask : '0;
	assign mem_wstrb = do_store ? size_mask : '0;

	always_comb begin
		case (funct3)
			`F3_LB:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			`F3_LBU: load_data = {24'b0, mem_rdata[7:0]};
			`F3_LH:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			`F3_LHU: load_data = {16'b0, mem_rdata[15:0]};
			default: load_data = mem_rdata;  // LW
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/rv32_next_pc.sv
/* Next pc for the executed word. A trap holds pc, which stalls the program on the
   faulting word until the environment steps in. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module rv32_next_pc (
	input  rv32_pkg::word_t   pc,
	input  rv32_pkg::word_t   insn_addr,
	input  rv32_pkg::word_t   imm,
	input  rv32_pkg::word_t   op_a,
	input  logic              is_branch,
	input  logic              is_jump,
	input  logic              jump_reg,
	input  rv32_pkg::funct3_t funct3,
	input  logic              lt,
	input  logic              ltu,
	input  logic              eq,
	input  logic              insn_valid,
	input  logic              insn_complete,
	input  logic              trap,
	output rv32_pkg::word_t   pc_next,
	output logic              pc_next_valid
);
	import rv32_pkg::*;

	logic  taken;
	logic  redirect;
	word_t seq_pc;
	word_t target;

	always_comb begin
		case (funct3)
			`F3_BEQ:  taken = eq;
			`F3_BNE:  taken = !eq;
			`F3_BLT:  taken = lt;
			`F3_BGE:  taken = !lt;
			`F3_BLTU: taken = ltu;
			`F3_BGEU: taken = !ltu;
			default:  taken = 1'b0;
		endcase
	end

	assign seq_pc   = insn_addr + 32'd4;
	assign target   = jump_reg ? ((op_a + imm) & `PC_ALIGN_MASK) : insn_addr + imm;
	assign redirect = is_jump || (is_branch && taken);

	assign pc_next = trap ? pc : (redirect ? target : seq_pc);

	// Control transfers wait for their operands before the target counts
	assign pc_next_valid = (is_jump || is_branch) ? insn_complete : insn_valid;

endmodule

`default_nettype wire

// File: rtl/rv32_writeback.sv
/* Destination data select. WB_NONE gives zero, which covers idle, trapped and
   no-destination words. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module rv32_writeback (
	input  rv32_pkg::wb_sel_t  wb_sel,
	input  rv32_pkg::word_t    alu_result,
	input  rv32_pkg::word_t    load_data,
	input  rv32_pkg::word_t    imm,
	input  rv32_pkg::word_t    insn_addr,
	input  logic [11:0]        csr_addr,
	input  rv32_pkg::counter_t csr_cycle,
	input  rv32_pkg::counter_t csr_time,
	input  rv32_pkg::counter_t csr_instret,
	output rv32_pkg::word_t    rd_wdata
);
	import rv32_pkg::*;

	counter_t counter;
	word_t    csr_word;

	always_comb begin
		case (csr_addr)
			`CSR_CYCLE, `CSR_CYCLEH: counter = csr_cycle;
			`CSR_TIME, `CSR_TIMEH:   counter = csr_time;
			default:                 counter = csr_instret;  // Decode traps the rest
		endcase
	end

	assign csr_word = csr_addr[7] ? counter[63:32] : counter[31:0];  // 0xC8x are high

	always_comb begin
		case (wb_sel)
			`WB_ALU:  rd_wdata = alu_result;
			`WB_LOAD: rd_wdata = load_data;
			`WB_IMM:  rd_wdata = imm;
			`WB_LINK: rd_wdata = insn_addr + 32'd4;
			`WB_CSR:  rd_wdata = csr_word;
			default:  rd_wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/comb_rv32.sv
/* Stateless RV32I executor: one word per call, no clock. Outputs hold while the
   inputs hold, so a host may keep a ready low for as long as it needs. */
`timescale 1ns/1ps
`default_nettype none

module comb_rv32 (
	  output logic                trap

	, input  rv32_pkg::word_t     pc
	, output rv32_pkg::word_t     pc_next
	, output logic                pc_next_valid
	, output rv32_pkg::word_t     insn_addr

	, input  rv32_pkg::word_t     insn
	, input  logic                insn_valid
	, output logic                insn_complete

	, output rv32_pkg::reg_addr_t rs1_addr
	, output rv32_pkg::reg_addr_t rs2_addr
	, output rv32_pkg::reg_addr_t rd_addr
	, output logic                rs1_addr_valid
	, output logic                rs2_addr_valid
	, output logic                rd_addr_valid
	, output logic                rs1_request
	, output logic                rs2_request
	, output logic                rd_request

	, input  rv32_pkg::word_t     rs1_rdata
	, input  rv32_pkg::word_t     rs2_rdata
	, output rv32_pkg::word_t     rd_wdata
	, input  logic                rs1_ready
	, input  logic                rs2_ready
	, input  logic                rd_ready

	, output logic                mem_valid
	, output logic                mem_instr
	, input  logic                mem_ready
	, output rv32_pkg::word_t     mem_addr
	, output rv32_pkg::word_t     mem_wdata
	, output rv32_pkg::strb_t     mem_wstrb
	, output rv32_pkg::strb_t     mem_rmask
	, input  rv32_pkg::word_t     mem_rdata

	, input  rv32_pkg::counter_t  csr_time
	, input  rv32_pkg::counter_t  csr_cycle
	, input  rv32_pkg::counter_t  csr_instret
);
	import rv32_pkg::*;

	word_t       op_a;
	word_t       op_b;       // Also the store data
	word_t       imm;
	funct3_t     funct3;
	logic        alt_op;
	logic        alu_en;
	logic        is_load;
	logic        is_store;
	logic        is_branch;
	logic        is_jump;
	logic        jump_reg;
	wb_sel_t     wb_sel;
	logic [11:0] csr_addr;
	word_t       alu_result;
	logic        lt;
	logic        ltu;
	logic        eq;
	word_t       load_data;

	rv32_decode u_decode (
		.pc             (pc),
		.insn           (insn),
		.insn_valid     (insn_valid),
		.rs1_rdata      (rs1_rdata),
		.rs2_rdata      (rs2_rdata),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.rd_ready       (rd_ready),
		.mem_ready      (mem_ready),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rd_addr        (rd_addr),
		.rs1_addr_valid (rs1_addr_valid),
		.rs2_addr_valid (rs2_addr_valid),
		.rd_addr_valid  (rd_addr_valid),
		.rs1_request    (rs1_request),
		.rs2_request    (rs2_request),
		.rd_request     (rd_request),
		.op_a           (op_a),
		.op_b           (op_b),
		.imm            (imm),
		.insn_addr      (insn_addr),
		.funct3         (funct3),
		.alt_op         (alt_op),
		.alu_en         (alu_en),
		.is_load        (is_load),
		.is_store       (is_store),
		.is_branch      (is_branch),
		.is_jump        (is_jump),
		.jump_reg       (jump_reg),
		.wb_sel         (wb_sel),
		.csr_addr       (csr_addr),
		.trap           (trap),
		.insn_complete  (insn_complete)
	);

	rv32_alu u_alu (
		.op_a       (op_a),
		.op_b       (op_b),
		.funct3     (funct3),
		.alt_op     (alt_op),
		.alu_en     (alu_en),
		.alu_result (alu_result),
		.lt         (lt),
		.ltu        (ltu),
		.eq         (eq)
	);

	rv32_lsu u_lsu (
		.insn_valid (insn_valid),
		.is_load    (is_load),
		.is_store   (is_store),
		.funct3     (funct3),
		.op_a       (op_a),
		.imm        (imm),
		.store_data (op_b),
		.mem_rdata  (mem_rdata),
		.mem_valid  (mem_valid),
		.mem_instr  (mem_instr),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.mem_rmask  (mem_rmask),
		.load_data  (load_data)
	);

	rv32_next_pc u_next_pc (
		.pc            (pc),
		.insn_addr     (insn_addr),
		.imm           (imm),
		.op_a          (op_a),
		.is_branch     (is_branch),
		.is_jump       (is_jump),
		.jump_reg      (jump_reg),
		.funct3        (funct3),
		.lt            (lt),
		.ltu           (ltu),
		.eq            (eq),
		.insn_valid    (insn_valid),
		.insn_complete (insn_complete),
		.trap          (trap),
		.pc_next       (pc_next),
		.pc_next_valid (pc_next_valid)
	);

	rv32_writeback u_writeback (
		.wb_sel      (wb_sel),
		.alu_result  (alu_result),
		.load_data   (load_data),
		.imm         (imm),
		.insn_addr   (insn_addr),
		.csr_addr    (csr_addr),
		.csr_cycle   (csr_cycle),
		.csr_time    (csr_time),
		.csr_instret (csr_instret),
		.rd_wdata    (rd_wdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_comb_rv32.sv
/* Random testbench for the combinational RV32I executor. The clock only paces the
   stimulus and arst_n is not wired to the DUT, which has neither. */
`timescale 1ns/1ps
`default_nettype none
`include "rv32_params.svh"

module tb_comb_rv32;
	import rv32_pkg::*;

	localparam int PERIOD_NS    = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS    = 5000;
	localparam int SEED         = 70451;
	localparam int TIMEOUT_NS   = (NUM_TESTS + RESET_CYCLES + 50) * PERIOD_NS;

	logic      clk;
	logic      arst_n;
	word_t     pc;
	word_t     insn;
	logic      insn_valid;
	word_t     rs1_rdata;
	word_t     rs2_rdata;
	logic      rs1_ready;
	logic      rs2_ready;
	logic      rd_ready;
	logic      mem_ready;
	word_t     mem_rdata;
	counter_t  csr_cycle;
	counter_t  csr_time;
	counter_t  csr_instret;

	logic      trap;
	word_t     pc_next;
	logic      pc_next_valid;
	word_t     insn_addr;
	logic      insn_complete;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	logic      rs1_addr_valid;
	logic      rs2_addr_valid;
	logic      rd_addr_valid;
	logic      rs1_request;
	logic      rs2_request;
	logic      rd_request;
	word_t     rd_wdata;
	logic      mem_valid;
	logic      mem_instr;
	word_t     mem_addr;
	word_t     mem_wdata;
	strb_t     mem_wstrb;
	strb_t     mem_rmask;

	// Reference model outputs
	logic      exp_trap;
	word_t     exp_pc_next;
	logic      exp_pc_next_valid;
	logic      exp_complete;
	reg_addr_t exp_rs1_addr;
	reg_addr_t exp_rs2_addr;
	reg_addr_t exp_rd_addr;
	logic      exp_rs1_valid;
	logic      exp_rs2_valid;
	logic      exp_rd_valid;
	logic      exp_rs1_request;
	logic      exp_rs2_request;
	logic      exp_rd_request;
	word_t     exp_rd_wdata;
	logic      exp_mem_valid;
	word_t     exp_mem_addr;
	word_t     exp_mem_wdata;
	strb_t     exp_wstrb;
	strb_t     exp_rmask;

	int        test_count;
	string     test_label;

	comb_rv32 dut (
		.trap           (trap),
		.pc             (pc),
		.pc_next        (pc_next),
		.pc_next_valid  (pc_next_valid),
		.insn_addr      (insn_addr),
		.insn           (insn),
		.insn_valid     (insn_valid),
		.insn_complete  (insn_complete),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rd_addr        (rd_addr),
		.rs1_addr_valid (rs1_addr_valid),
		.rs2_addr_valid (rs2_addr_valid),
		.rd_addr_valid  (rd_addr_valid),
		.rs1_request    (rs1_request),
		.rs2_request    (rs2_request),
		.rd_request     (rd_request),
		.rs1_rdata      (rs1_rdata),
		.rs2_rdata      (rs2_rdata),
		.rd_wdata       (rd_wdata),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.rd_ready       (rd_ready),
		.mem_valid      (mem_valid),
		.mem_instr      (mem_instr),
		.mem_ready      (mem_ready),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wstrb      (mem_wstrb),
		.mem_rmask      (mem_rmask),
		.mem_rdata      (mem_rdata),
		.csr_time       (csr_time),
		.csr_cycle      (csr_cycle),
		.csr_instret    (csr_instret)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error [%s #%0d] %s: expected %h, actual %h",
				test_label, test_count, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Output mismatch in test %0d", test_count);
		end
	endtask

	// Integer result of OP and OP-IMM as the ISA defines it
	function automatic word_t alu_ref(input funct3_t f3, input logic alt, input word_t x,
		input word_t y);
		logic signed [31:0] sx;
		logic signed [31:0] sy;
		word_t              r;
		sx = x;
		sy = y;
		case (f3)
			`F3_ADD:  r = alt ? x - y : x + y;
			`F3_SLL:  r = x << y[4:0];
			`F3_SLT:  r = (sx < sy) ? 32'd1 : 32'd0;
			`F3_SLTU: r = (x < y) ? 32'd1 : 32'd0;
			`F3_XOR:  r = x ^ y;
			`F3_SR: begin
				if (alt)
					r = sx >>> y[4:0];
				else
					r = x >> y[4:0];
			end
			`F3_OR:   r = x | y;
			default:  r = x & y;
		endcase
		return r;
	endfunction

	task automatic make_insn(output word_t w, output string label);
		funct3_t     f3;
		logic [2:0]  pick;
		int unsigned kind;
		w = $urandom;
		f3 = w[14:12];
		kind = $urandom_range(0, 11);
		case (kind)
			0: begin w[6:0] = `OPC_LUI; label = "lui"; end
			1: begin w[6:0] = `OPC_AUIPC; label = "auipc"; end
			2: begin w[6:0] = `OPC_JAL; label = "jal"; end
			3: begin
				w[6:0] = `OPC_JALR;
				w[14:12] = `F3_JALR;
				label = "jalr";
			end
			4: begin
				pick = 3'($urandom_range(0, 5));
				w[6:0] = `OPC_BRANCH;
				w[14:12] = (pick < 3'd2) ? pick : pick + 3'd2;  // Skip 010 and 011
				label = "branch";
			end
			5: begin
				pick = 3'($urandom_range(0, 4));
				w[6:0] = `OPC_LOAD;
				w[14:12] = (pick < 3'd3) ? pick : pick + 3'd1;  // Skip 011
				label = "load";
			end
			6: begin
				w[6:0] = `OPC_STORE;
				w[14:12] = 3'($urandom_range(0, 2));
				label = "store";
			end
			7: begin
				w[6:0] = `OPC_OP;
				w[31:25] = `F7_BASE;
				if ((f3 == `F3_ADD || f3 == `F3_SR) && $urandom_range(0, 1) != 0)
					w[31:25] = `F7_ALT;
				label = "op";
			end
			8: begin
				w[6:0] = `OPC_OP_IMM;
				if (f3 == `F3_SLL)
					w[31:25] = `F7_BASE;
				else if (f3 == `F3_SR)
					w[31:25] = ($urandom_range(0, 1) != 0) ? `F7_ALT : `F7_BASE;
				label = "op_imm";
			end
			9: begin
				pick = 3'($urandom_range(0, 5));
				w[6:0] = `OPC_SYSTEM;
				w[14:12] = `F3_CSRRS;
				w[19:15] = '0;
				w[31:20] = (pick < 3'd3) ? `CSR_CYCLE + 12'(pick) :
					`CSR_CYCLEH + 12'(pick - 3'd3);
				label = "csr";
			end
			10: begin
				w[1:0] = 2'($urandom_range(0, 2));  // 16-bit forms
				label = "compressed";
			end
			default: begin
				case ($urandom_range(0, 3))
					0: w[6:0] = `OPC_SYSTEM;
					1: w[6:0] = `OPC_OP;
					2: w[6:0] = `OPC_OP_IMM;
					default: w[6:0] = `OPC_LOAD;
				endcase
				label = "random";
			end
		endcase
		// Extra weight on x0 operands and destination
		if ($urandom_range(0, 7) == 0 && kind != 10)
			w[19:15] = '0;
		if ($urandom_range(0, 7) == 0 && kind != 10)
			w[24:20] = '0;
		if ($urandom_range(0, 7) == 0 && kind != 10)
			w[11:7] = '0;
	endtask

	task automatic drive_inputs();
		word_t w;
		string label;
		make_insn(w, label);
		insn = w;
		test_label = label;
		insn_valid = ($urandom_range(0, 9) != 0);
		pc = $urandom & 32'hFFFF_FFFC;
		rs1_rdata = $urandom;
		rs2_rdata = ($urandom_range(0, 3) == 0) ? rs1_rdata : $urandom;  // Equal operands
		mem_rdata = $urandom;
		rs1_ready = ($urandom_range(0, 3) != 0);
		rs2_ready = ($urandom_range(0, 3) != 0);
		rd_ready = ($urandom_range(0, 3) != 0);
		mem_ready = ($urandom_range(0, 3) != 0);
		csr_cycle = {$urandom, $urandom};
		csr_time = {$urandom, $urandom};
		csr_instret = {$urandom, $urandom};
	endtask

	task automatic predict();
		funct3_t    f3;
		logic [6:0] f7;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		word_t      imm_i;
		word_t      imm_s;
		word_t      imm_b;
		word_t      imm_j;
		word_t      imm_u;
		word_t      base;
		word_t      a;
		word_t      b;
		word_t      target;
		word_t      wdata;
		word_t      addr;
		strb_t      size;
		logic       legal;
		logic       use_rs1;
		logic       use_rs2;
		logic       use_rd;
		logic       load_op;
		logic       store_op;
		logic       ctrl;
		logic       redirect;

		f3 = insn[14:12];
		f7 = insn[31:25];
		rs1 = insn[19:15];
		rs2 = insn[24:20];
		imm_i = {{20{insn[31]}}, insn[31:20]};
		imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
		imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
		imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
		imm_u = {insn[31:12], 12'b0};
		base = pc;  // Driven word aligned
		a = (rs1 == '0) ? '0 : rs1_rdata;
		b = (rs2 == '0) ? '0 : rs2_rdata;
		size = (f3[1:0] == 2'b00) ? 4'b0001 : ((f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111);
		legal = 1'b1;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd = 1'b0;
		load_op = 1'b0;
		store_op = 1'b0;
		ctrl = 1'b0;
		redirect = 1'b0;
		target = '0;
		wdata = '0;
		addr = '0;

		case (insn[6:0])
			`OPC_LUI: begin use_rd = 1'b1; wdata = imm_u; end
			`OPC_AUIPC: begin use_rd = 1'b1; wdata = base + imm_u; end
			`OPC_JAL: begin
				use_rd = 1'b1;
				ctrl = 1'b1;
				redirect = 1'b1;
				wdata = base + 32'd4;
				target = base + imm_j;
			end
			`OPC_JALR: begin
				legal = (f3 == `F3_JALR);
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				ctrl = 1'b1;
				redirect = 1'b1;
				wdata = base + 32'd4;
				target = (a + imm_i) & 32'hFFFF_FFFE;
			end
			`OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				ctrl = 1'b1;
				target = base + imm_b;
				case (f3)
					`F3_BEQ:  redirect = (a == b);
					`F3_BNE:  redirect = (a != b);
					`F3_BLT:  redirect = ($signed(a) < $signed(b));
					`F3_BGE:  redirect = ($signed(a) >= $signed(b));
					`F3_BLTU: redirect = (a < b);
					`F3_BGEU: redirect = (a >= b);
					default:  legal = 1'b0;
				endcase
			end
			`OPC_LOAD: begin
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				load_op = 1'b1;
				addr = a + imm_i;
				case (f3)
					`F3_LB:  wdata = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
					`F3_LBU: wdata = {24'b0, mem_rdata[7:0]};
					`F3_LH:  wdata = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
					`F3_LHU: wdata = {16'b0, mem_rdata[15:0]};
					`F3_LW:  wdata = mem_rdata;
					default: legal = 1'b0;
				endcase
			end
			`OPC_STORE: begin
				legal = (f3 == `F3_SB || f3 == `F3_SH || f3 == `F3_SW);
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				store_op = 1'b1;
				addr = a + imm_s;
			end
			`OPC_OP: begin
				legal = (f7 == `F7_BASE) ||
					(f7 == `F7_ALT && (f3 == `F3_ADD || f3 == `F3_SR));
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd = 1'b1;
				wdata = alu_ref(f3, f7 == `F7_ALT, a, b);
			end
			`OPC_OP_IMM: begin
				if (f3 == `F3_SLL)
					legal = (f7 == `F7_BASE);
				else if (f3 == `F3_SR)
					legal = (f7 == `F7_BASE) || (f7 == `F7_ALT);
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				wdata = alu_ref(f3, f3 == `F3_SR && f7 == `F7_ALT, a, imm_i);
			end
			`OPC_SYSTEM: begin
				legal = (f3 == `F3_CSRRS) && (rs1 == '0);
				use_rd = 1'b1;
				case (insn[31:20])
					`CSR_CYCLE:    wdata = csr_cycle[31:0];
					`CSR_CYCLEH:   wdata = csr_cycle[63:32];
					`CSR_TIME:     wdata = csr_time[31:0];
					`CSR_TIMEH:    wdata = csr_time[63:32];
					`CSR_INSTRET:  wdata = csr_instret[31:0];
					`CSR_INSTRETH: wdata = csr_instret[63:32];
					default:       legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;  // Includes every 16-bit form
		endcase

		// A trapped word touches no port
		if (!legal) begin
			use_rs1 = 1'b0;
			use_rs2 = 1'b0;
			use_rd = 1'b0;
			load_op = 1'b0;
			store_op = 1'b0;
			ctrl = 1'b0;
			redirect = 1'b0;
			wdata = '0;
		end

		exp_rs1_valid = insn_valid && use_rs1;
		exp_rs2_valid = insn_valid && use_rs2;
		exp_rd_valid = insn_valid && use_rd;
		exp_rs1_addr = exp_rs1_valid ? rs1 : '0;
		exp_rs2_addr = exp_rs2_valid ? rs2 : '0;
		exp_rd_addr = exp_rd_valid ? insn[11:7] : '0;
		exp_rs1_request = exp_rs1_valid && (rs1 != '0);
		exp_rs2_request = exp_rs2_valid && (rs2 != '0);
		exp_rd_request = exp_rd_valid && (insn[11:7] != '0);
		exp_complete = insn_valid && (!use_rs1 || rs1_ready) && (!use_rs2 || rs2_ready) &&
			(!use_rd || rd_ready) && (!(load_op || store_op) || mem_ready);
		exp_trap = insn_valid && !legal;
		exp_mem_valid = insn_valid && (load_op || store_op);
		exp_mem_addr = exp_mem_valid ? addr : '0;
		exp_mem_wdata = (insn_valid && store_op) ? b : '0;
		exp_wstrb = (insn_valid && store_op) ? size : '0;
		exp_rmask = (insn_valid && load_op) ? size : '0;
		exp_rd_wdata = insn_valid ? wdata : '0;
		exp_pc_next = exp_trap ? pc : (redirect ? target : base + 32'd4);
		exp_pc_next_valid = ctrl ? exp_complete : insn_valid;
	endtask

	task automatic check_outputs();
		predict();
		compare("trap", 32'(exp_trap), 32'(trap));
		compare("insn_complete", 32'(exp_complete), 32'(insn_complete));
		compare("pc_next_valid", 32'(exp_pc_next_valid), 32'(pc_next_valid));
		if (insn_valid)
			compare("pc_next", exp_pc_next, pc_next);
		compare("insn_addr", pc, insn_addr);
		compare("rs1_addr", 32'(exp_rs1_addr), 32'(rs1_addr));
		compare("rs2_addr", 32'(exp_rs2_addr), 32'(rs2_addr));
		compare("rd_addr", 32'(exp_rd_addr), 32'(rd_addr));
		compare("rs1_addr_valid", 32'(exp_rs1_valid), 32'(rs1_addr_valid));
		compare("rs2_addr_valid", 32'(exp_rs2_valid), 32'(rs2_addr_valid));
		compare("rd_addr_valid", 32'(exp_rd_valid), 32'(rd_addr_valid));
		compare("rs1_request", 32'(exp_rs1_request), 32'(rs1_request));
		compare("rs2_request", 32'(exp_rs2_request), 32'(rs2_request));
		compare("rd_request", 32'(exp_rd_request), 32'(rd_request));
		compare("rd_wdata", exp_rd_wdata, rd_wdata);
		compare("mem_valid", 32'(exp_mem_valid), 32'(mem_valid));
		compare("mem_instr", 32'd0, 32'(mem_instr));
		compare("mem_addr", exp_mem_addr, mem_addr);
		compare("mem_wdata", exp_mem_wdata, mem_wdata);
		compare("mem_wstrb", 32'(exp_wstrb), 32'(mem_wstrb));
		compare("mem_rmask", 32'(exp_rmask), 32'(mem_rmask));
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired after %0d ns with %0d tests done",
			TIMEOUT_NS, test_count);
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		pc = '0;
		insn = '0;
		insn_valid = 1'b0;
		rs1_rdata = '0;
		rs2_rdata = '0;
		rs1_ready = 1'b0;
		rs2_ready = 1'b0;
		rd_ready = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		csr_cycle = '0;
		csr_time = '0;
		csr_instret = '0;
		test_count = 0;
		test_label = "reset";
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		while (test_count < NUM_TESTS) begin
			@(negedge clk);
			drive_inputs();
			@(posedge clk);
			check_outputs();
			test_count = test_count + 1;
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/rv32_pkg.sv
rtl/rv32_decode.sv
rtl/rv32_alu.sv
rtl/rv32_lsu.sv
rtl/rv32_next_pc.sv
rtl/rv32_writeback.sv
rtl/comb_rv32.sv
testbench/tb_comb_rv32.sv

// File: Makefile
# Verilator build and run; a failing run exits non-zero through $fatal

VERILATOR ?= verilator
TOP       ?= tb_comb_rv32
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
